/* rtl/serial_pkg.sv */
`default_nettype none

package serial_pkg;

   // Word width, fixed by the ISA, so also the number of bit cycles
   localparam int XLEN = 32;

   // Major opcodes, instruction bits 6:2
   typedef enum logic [4:0] {
      OPC_LOAD   = 5'b00000,
      OPC_OPIMM  = 5'b00100,
      OPC_STORE  = 5'b01000,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_BRANCH = 5'b11000
   } opcode_e;

   // Result source of the serial ALU
   typedef enum logic [1:0] {
      ALU_ADD    = 2'd0,
      ALU_SLT    = 2'd1,
      ALU_BOOL   = 2'd2,
      ALU_PASS_B = 2'd3
   } alu_sel_e;

   // Immediate layouts
   typedef enum logic [1:0] {
      FMT_I = 2'd0,
      FMT_S = 2'd1,
      FMT_B = 2'd2,
      FMT_U = 2'd3
   } imm_fmt_e;

   typedef struct packed {
      alu_sel_e   alu_sel;
      logic       alu_sub;
      logic [1:0] alu_bool_op;
      logic       cmp_eq;
      logic       cmp_signed;
      logic       cmp_invert;
      logic       op_b_imm;
      logic       rd_op;
      logic       branch_op;
      logic       slt_op;
      imm_fmt_e   imm_fmt;
   } ctrl_t;

endpackage

`default_nettype wire

/* rtl/instr_decode.sv */
`default_nettype none

module instr_decode #(
   parameter bit PRE_REGISTER = 1'b1
) (
   input  wire               clk,
   input  wire               i_wb_en,
   input  wire [31:2]        i_wb_rdt,
   output serial_pkg::ctrl_t o_ctrl
);
   import serial_pkg::*;

   logic [4:0] opcode;
   logic [2:0] funct3;
   logic       imm30;

   logic       op_or_opimm;
   logic       co_slt_op;
   ctrl_t      co_ctrl;

   // OP and OP-IMM share every funct3 decode below
   assign op_or_opimm = !opcode[4] & opcode[2] & !opcode[0];
   assign co_slt_op   = op_or_opimm & (funct3[2:1] == 2'b01);

   always_comb begin
      // Subtract for sub, slt* and every branch
      co_ctrl.alu_sub     = funct3[1] | funct3[0] | (opcode[3] & imm30) | opcode[4];
      co_ctrl.alu_bool_op = funct3[1:0];

      // beq/bne compare for equality, the rest for less-than
      co_ctrl.cmp_eq      = funct3[2:1] == 2'b00;
      // Cleared for sltu, sltiu, bltu and bgeu
      co_ctrl.cmp_signed  = ~((funct3[0] & funct3[1]) | (funct3[1] & funct3[2]));
      // bne, bge, bgeu only; sltu also has funct3[0] set
      co_ctrl.cmp_invert  = opcode[4] & funct3[0];

      // OP-IMM and LUI take the immediate as operand B
      co_ctrl.op_b_imm    = !opcode[3] | opcode[0];
      // False for STORE and BRANCH
      co_ctrl.rd_op       = opcode[2];
      co_ctrl.branch_op   = opcode[4] & !opcode[2];
      co_ctrl.slt_op      = co_slt_op;

      case (opcode_e'(opcode))
         OPC_LOAD: begin
            co_ctrl.alu_sel = ALU_ADD;
            co_ctrl.imm_fmt = FMT_I;
         end
         OPC_OPIMM, OPC_OP: begin
            if (co_slt_op) begin
               co_ctrl.alu_sel = ALU_SLT;
            end else if (funct3 == 3'b000) begin
               co_ctrl.alu_sel = ALU_ADD;
            end else begin
               co_ctrl.alu_sel = ALU_BOOL;
            end
            co_ctrl.imm_fmt = FMT_I;
         end
         OPC_STORE: begin
            co_ctrl.alu_sel = ALU_ADD;
            co_ctrl.imm_fmt = FMT_S;
         end
         OPC_BRANCH: begin
            co_ctrl.alu_sel = ALU_ADD;
            co_ctrl.imm_fmt = FMT_B;
         end
         OPC_LUI: begin
            co_ctrl.alu_sel = ALU_PASS_B;
            co_ctrl.imm_fmt = FMT_U;
         end
         default: begin
            co_ctrl.alu_sel = ALU_ADD;
            co_ctrl.imm_fmt = FMT_I;
         end
      endcase
   end

   // Either way the control word is valid from the cycle after the strobe
   generate
      if (PRE_REGISTER) begin : g_pre_reg
         // Register the raw fields, decode behind them
         always_ff @(posedge clk) begin
            if (i_wb_en) begin
               opcode <= i_wb_rdt[6:2];
               funct3 <= i_wb_rdt[14:12];
               imm30  <= i_wb_rdt[30];
            end
         end

         assign o_ctrl = co_ctrl;
      end else begin : g_post_reg
         // Decode straight from the bus, register the result
         always_comb begin
            opcode = i_wb_rdt[6:2];
            funct3 = i_wb_rdt[14:12];
            imm30  = i_wb_rdt[30];
         end

         always_ff @(posedge clk) begin
            if (i_wb_en) begin
               o_ctrl <= co_ctrl;
            end
         end
      end
   endgenerate

endmodule

`default_nettype wire

/* rtl/imm_decode.sv */
`default_nettype none

module imm_decode (
   input  wire                  clk,
   input  wire                  i_wb_en,
   input  wire [31:7]           i_wb_rdt,
   input  wire serial_pkg::imm_fmt_e i_fmt,
   input  wire                  i_run,
   output logic                 o_imm_bit
);
   import serial_pkg::*;

   // Instruction bits that can hold immediate data, kept at their own indices
   logic [31:7]      raw;
   logic [XLEN-1:0]  imm_word;
   logic [XLEN-1:1]  imm_sr;
   logic             run_q;
   logic             first;

   always_ff @(posedge clk) begin
      if (i_wb_en) begin
         raw <= i_wb_rdt;
      end
   end

   // Sign-extended immediate for the current format
   always_comb begin
      case (i_fmt)
         FMT_I:   imm_word = {{21{raw[31]}}, raw[30:20]};
         FMT_S:   imm_word = {{21{raw[31]}}, raw[30:25], raw[11:7]};
         FMT_B:   imm_word = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
         default: imm_word = {raw[31:12], 12'b0};
      endcase
   end

   // First run cycle, the format is settled only from here on
   assign first = i_run & !run_q;

   always_ff @(posedge clk) begin
      run_q <= i_run;
      if (first) begin
         imm_sr <= imm_word[XLEN-1:1];
      end else if (i_run) begin
         imm_sr <= {1'b0, imm_sr[XLEN-1:2]};
      end
   end

   // Bit 0 comes straight from the assembled word, the rest from the shifter
   assign o_imm_bit = first ? imm_word[0] : imm_sr[1];

   a_fmt_known: assert property (@(posedge clk) i_run |-> !$isunknown(i_fmt))
      else $error("imm_decode: immediate format unknown during bit cycles");

endmodule

`default_nettype wire

/* rtl/serial_regs.sv */
`default_nettype none

module serial_regs (
   input  wire                          clk,
   input  wire                          i_rst_n,
   input  wire                          i_wb_en,
   input  wire [serial_pkg::XLEN-1:0]   i_rs1,
   input  wire [serial_pkg::XLEN-1:0]   i_rs2,
   input  wire                          i_rd_bit,
   input  wire                          i_cmp,
   input  wire serial_pkg::ctrl_t       i_ctrl,
   output logic                         o_rs1_bit,
   output logic                         o_rs2_bit,
   output logic                         o_run,
   output logic                         o_first,
   output logic                         o_last,
   output logic                         o_busy,
   output logic                         o_rd_valid,
   output logic                         o_rd_wen,
   output logic [serial_pkg::XLEN-1:0]  o_rd_data,
   output logic                         o_branch_taken
);
   import serial_pkg::*;

   localparam int CNT_W = $clog2(XLEN);

   logic [CNT_W-1:0] cnt;
   logic [XLEN-1:0]  rs1_sr;
   logic [XLEN-1:0]  rs2_sr;
   logic [XLEN-1:1]  rd_sr;
   logic             start;

   assign start   = i_wb_en & !o_busy;
   assign o_run   = o_busy;
   assign o_first = o_busy & (cnt == '0);
   assign o_last  = o_busy & (cnt == CNT_W'(XLEN - 1));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_busy         <= 1'b0;
         cnt            <= '0;
         o_rd_valid     <= 1'b0;
         o_rd_wen       <= 1'b0;
         o_branch_taken <= 1'b0;
      end else begin
         o_rd_valid <= 1'b0;
         if (start) begin
            o_busy <= 1'b1;
            cnt    <= '0;
         end else if (o_busy) begin
            cnt <= cnt + 1'b1;
            if (o_last) begin
               o_busy         <= 1'b0;
               o_rd_valid     <= 1'b1;
               o_rd_wen       <= i_ctrl.rd_op;
               o_branch_taken <= i_ctrl.branch_op & i_cmp;
            end
         end
      end
   end

   // Operands out LSB first, result in from the top
   always_ff @(posedge clk) begin
      if (start) begin
         rs1_sr <= i_rs1;
         rs2_sr <= i_rs2;
      end else if (o_busy) begin
         rs1_sr <= rs1_sr >> 1;
         rs2_sr <= rs2_sr >> 1;
         rd_sr  <= {i_rd_bit, rd_sr[XLEN-1:2]};
      end
      // SLT result is the compare flag in bit 0
      if (o_last) begin
         o_rd_data <= {i_rd_bit, rd_sr[XLEN-1:2], i_ctrl.slt_op ? i_cmp : rd_sr[1]};
      end
   end

   assign o_rs1_bit = rs1_sr[0];
   assign o_rs2_bit = rs2_sr[0];

   a_no_start_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_busy |-> !i_wb_en)
      else $error("serial_regs: start strobe while busy");

   a_valid_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_rd_valid |=> !o_rd_valid)
      else $error("serial_regs: result valid longer than one cycle");

endmodule

`default_nettype wire

/* rtl/serial_alu.sv */
`default_nettype none

module serial_alu (
   input  wire                    clk,
   input  wire serial_pkg::ctrl_t i_ctrl,
   input  wire                    i_rs1_bit,
   input  wire                    i_rs2_bit,
   input  wire                    i_imm_bit,
   input  wire                    i_run,
   input  wire                    i_first,
   input  wire                    i_last,
   output logic                   o_rd_bit,
   output logic                   o_cmp
);
   import serial_pkg::*;

   logic op_a;
   logic op_b;
   logic b_inv;
   logic carry_q;
   logic carry_in;
   logic carry_out;
   logic sum;
   logic eq_q;
   logic eq_now;
   logic bool_bit;
   logic lt;
   logic cmp_raw;

   assign op_a  = i_rs1_bit;
   assign op_b  = i_ctrl.op_b_imm ? i_imm_bit : i_rs2_bit;
   assign b_inv = op_b ^ i_ctrl.alu_sub;

   // Carry preset to 1 on bit 0 to finish the two's complement
   assign carry_in  = i_first ? i_ctrl.alu_sub : carry_q;
   assign sum       = op_a ^ b_inv ^ carry_in;
   assign carry_out = (op_a & b_inv) | (carry_in & (op_a ^ b_inv));

   // Equality accumulated over all bits so far
   assign eq_now = (i_first | eq_q) & ~(op_a ^ op_b);

   always_ff @(posedge clk) begin
      if (i_run) begin
         carry_q <= carry_out;
         eq_q    <= eq_now;
      end
   end

   always_comb begin
      case (i_ctrl.alu_bool_op)
         2'b00:   bool_bit = op_a ^ op_b;
         2'b10:   bool_bit = op_a | op_b;
         2'b11:   bool_bit = op_a & op_b;
         default: bool_bit = 1'b0;
      endcase
   end

   // Differing sign bits decide directly, else the difference sign does
   assign lt      = (op_a ^ op_b) ? (i_ctrl.cmp_signed ? op_a : op_b) : sum;
   assign cmp_raw = i_ctrl.cmp_eq ? eq_now : lt;
   assign o_cmp   = i_last & (cmp_raw ^ i_ctrl.cmp_invert);

   always_comb begin
      case (i_ctrl.alu_sel)
         ALU_ADD:    o_rd_bit = sum;
         ALU_SLT:    o_rd_bit = 1'b0;
         ALU_BOOL:   o_rd_bit = bool_bit;
         ALU_PASS_B: o_rd_bit = op_b;
         default:    o_rd_bit = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/serial_exec_top.sv */
`default_nettype none

module serial_exec_top #(
   parameter bit PRE_REGISTER = 1'b1
) (
   input  wire                          clk,
   input  wire                          i_rst_n,
   input  wire                          i_wb_en,
   input  wire [31:0]                   i_wb_rdt,
   input  wire [serial_pkg::XLEN-1:0]   i_rs1,
   input  wire [serial_pkg::XLEN-1:0]   i_rs2,
   output logic                         o_busy,
   output logic                         o_rd_valid,
   output logic                         o_rd_wen,
   output logic [serial_pkg::XLEN-1:0]  o_rd_data,
   output logic                         o_branch_taken
);
   import serial_pkg::*;

   ctrl_t ctrl;
   logic  imm_bit;
   logic  rs1_bit;
   logic  rs2_bit;
   logic  run;
   logic  first;
   logic  last;
   logic  rd_bit;
   logic  cmp;

   instr_decode #(
      .PRE_REGISTER (PRE_REGISTER)
   ) u_decode (
      .clk      (clk),
      .i_wb_en  (i_wb_en),
      .i_wb_rdt (i_wb_rdt[31:2]),
      .o_ctrl   (ctrl)
   );

   imm_decode u_immdec (
      .clk       (clk),
      .i_wb_en   (i_wb_en),
      .i_wb_rdt  (i_wb_rdt[31:7]),
      .i_fmt     (ctrl.imm_fmt),
      .i_run     (run),
      .o_imm_bit (imm_bit)
   );

   serial_regs u_regs (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_wb_en        (i_wb_en),
      .i_rs1          (i_rs1),
      .i_rs2          (i_rs2),
      .i_rd_bit       (rd_bit),
      .i_cmp          (cmp),
      .i_ctrl         (ctrl),
      .o_rs1_bit      (rs1_bit),
      .o_rs2_bit      (rs2_bit),
      .o_run          (run),
      .o_first        (first),
      .o_last         (last),
      .o_busy         (o_busy),
      .o_rd_valid     (o_rd_valid),
      .o_rd_wen       (o_rd_wen),
      .o_rd_data      (o_rd_data),
      .o_branch_taken (o_branch_taken)
   );

   serial_alu u_alu (
      .clk       (clk),
      .i_ctrl    (ctrl),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .i_run     (run),
      .i_first   (first),
      .i_last    (last),
      .o_rd_bit  (rd_bit),
      .o_cmp     (cmp)
   );

endmodule

`default_nettype wire

/* dv/tb_serial_exec.sv */
`default_nettype none

module tb_serial_exec;
   timeunit 1ns;
   timeprecision 1ps;
   import serial_pkg::*;

   // 20 register ops, 16 immediate ops, 12 compares, 3 LUI, 18 branches, 1 store
   localparam int N_INSTR     = 70;
   localparam int CYCLE_LIMIT = N_INSTR * 40 + 100;
   localparam logic [14:0] OP_F3     = {3'd7, 3'd6, 3'd4, 3'd0, 3'd0};
   localparam logic [11:0] OPIMM_F3  = {3'd7, 3'd6, 3'd4, 3'd0};
   localparam logic [17:0] BRANCH_F3 = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

   logic        clk = 1'b0;
   logic        i_rst_n;
   logic        i_wb_en;
   logic [31:0] i_wb_rdt;
   logic [31:0] i_rs1;
   logic [31:0] i_rs2;
   logic        o_busy;
   logic        o_rd_valid;
   logic        o_rd_wen;
   logic [31:0] o_rd_data;
   logic        o_branch_taken;

   logic [31:0] exp_data;
   logic        exp_wen;
   logic        exp_taken;
   logic        exp_check;
   logic        started;
   int          n_issued;
   int          n_results;
   int          cycles;
   integer      seed;

   always #20 clk = ~clk;

   serial_exec_top #(
      .PRE_REGISTER (1'b1)
   ) DUT (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_wb_en        (i_wb_en),
      .i_wb_rdt       (i_wb_rdt),
      .i_rs1          (i_rs1),
      .i_rs2          (i_rs2),
      .o_busy         (o_busy),
      .o_rd_valid     (o_rd_valid),
      .o_rd_wen       (o_rd_wen),
      .o_rd_data      (o_rd_data),
      .o_branch_taken (o_branch_taken)
   );

   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   function automatic logic [31:0] encode_op(input logic [2:0] f3, input logic sub);
      return {1'b0, sub, 5'b0, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
   endfunction

   function automatic logic [31:0] encode_opimm(input logic [2:0] f3, input logic [11:0] imm);
      return {imm, 5'd1, f3, 5'd3, 7'b0010011};
   endfunction

   function automatic logic [31:0] encode_lui(input logic [19:0] imm);
      return {imm, 5'd3, 7'b0110111};
   endfunction

   function automatic logic [31:0] encode_branch(input logic [2:0] f3, input logic [12:0] off);
      return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] encode_store(input logic [11:0] off);
      return {off[11:5], 5'd2, 5'd1, 3'b010, off[4:0], 7'b0100011};
   endfunction

   // Expected result from the RV32I rules
   task automatic predict(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b);
      opcode_e     opc;
      logic [2:0]  f3;
      logic [31:0] opb;
      logic        lt_s;
      logic        lt_u;
      opc  = opcode_e'(instr[6:2]);
      f3   = instr[14:12];
      opb  = (opc == OPC_OPIMM) ? {{20{instr[31]}}, instr[31:20]} : b;
      lt_s = $signed(a) < $signed(opb);
      lt_u = a < opb;
      exp_data  = '0;
      exp_wen   = 1'b1;
      exp_taken = 1'b0;
      exp_check = 1'b1;
      case (opc)
         OPC_OP, OPC_OPIMM: begin
            case (f3)
               3'b000:  exp_data = (opc == OPC_OP && instr[30]) ? a - opb : a + opb;
               3'b010:  exp_data = {31'b0, lt_s};
               3'b011:  exp_data = {31'b0, lt_u};
               3'b100:  exp_data = a ^ opb;
               3'b110:  exp_data = a | opb;
               3'b111:  exp_data = a & opb;
               default: exp_check = 1'b0;
            endcase
         end
         OPC_LUI: exp_data = {instr[31:12], 12'b0};
         OPC_BRANCH: begin
            exp_wen   = 1'b0;
            exp_check = 1'b0;
            case (f3)
               3'b000:  exp_taken = (a == b);
               3'b001:  exp_taken = (a != b);
               3'b100:  exp_taken = lt_s;
               3'b101:  exp_taken = !lt_s;
               3'b110:  exp_taken = lt_u;
               3'b111:  exp_taken = !lt_u;
               default: exp_taken = 1'b0;
            endcase
         end
         default: begin
            // STORE writes no register
            exp_wen   = 1'b0;
            exp_check = 1'b0;
         end
      endcase
   endtask

   task automatic execute(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b);
      @(negedge clk);
      predict(instr, a, b);
      i_wb_en  = 1'b1;
      i_wb_rdt = instr;
      i_rs1    = a;
      i_rs2    = b;
      started  = 1'b1;
      n_issued = n_issued + 1;
      @(negedge clk);
      i_wb_en = 1'b0;
      while (!o_rd_valid) @(negedge clk);
   endtask

   always @(negedge clk) begin
      if (i_rst_n && o_rd_valid) begin
         n_results <= n_results + 1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   a_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
      !started |-> !(o_busy || o_rd_valid || o_rd_wen || o_branch_taken))
      else begin
         $display("CHECK FAILED at %0t: %s expected 0000 got %b%b%b%b",
                  $time, "idle o_busy/o_rd_valid/o_rd_wen/o_branch_taken",
                  $sampled(o_busy), $sampled(o_rd_valid), $sampled(o_rd_wen),
                  $sampled(o_branch_taken));
         abort_run();
      end

   // Busy for the 32 bit cycles, then a valid pulse as busy falls
   a_timing: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_wb_en && !o_busy) |=> o_busy [*32] ##1 (o_rd_valid && !o_busy))
      else begin
         $display("CHECK FAILED at %0t: o_busy/o_rd_valid expected %s, got busy=%b valid=%b",
                  $time, "busy for 32 cycles then busy=0 valid=1",
                  $sampled(o_busy), $sampled(o_rd_valid));
         abort_run();
      end

   a_rd_data: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_rd_valid && exp_check) |-> (o_rd_data == exp_data))
      else begin
         $display("CHECK FAILED at %0t: o_rd_data expected %h got %h",
                  $time, $sampled(exp_data), $sampled(o_rd_data));
         abort_run();
      end

   a_rd_wen: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_rd_valid |-> (o_rd_wen == exp_wen))
      else begin
         $display("CHECK FAILED at %0t: o_rd_wen expected %b got %b",
                  $time, $sampled(exp_wen), $sampled(o_rd_wen));
         abort_run();
      end

   a_taken: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_rd_valid |-> (o_branch_taken == exp_taken))
      else begin
         $display("CHECK FAILED at %0t: o_branch_taken expected %b got %b",
                  $time, $sampled(exp_taken), $sampled(o_branch_taken));
         abort_run();
      end

   initial begin
      logic [31:0] a;
      logic [31:0] b;
      logic [11:0] imm;
      logic [31:0] simm;
      seed      = 32'hec6a;
      i_rst_n   = 1'b0;
      i_wb_en   = 1'b0;
      i_wb_rdt  = '0;
      i_rs1     = '0;
      i_rs2     = '0;
      started   = 1'b0;
      n_issued  = 0;
      n_results = 0;
      cycles    = 0;
      repeat (4) @(negedge clk);
      i_rst_n = 1'b1;
      // Some idle cycles before the first strobe
      repeat (3) @(negedge clk);

      for (int i = 0; i < 5; i++) begin
         for (int j = 0; j < 4; j++) begin
            a = $random(seed);
            b = $random(seed);
            execute(encode_op(OP_F3[i*3 +: 3], i == 1), a, b);
         end
      end
      for (int i = 0; i < 4; i++) begin
         for (int j = 0; j < 4; j++) begin
            a   = $random(seed);
            imm = 12'($random(seed));
            execute(encode_opimm(OPIMM_F3[i*3 +: 3], imm), a, 32'h0);
         end
      end

      // SLT forms with equal, sign-only and random operands
      for (int f = 2; f <= 3; f++) begin
         a = $random(seed);
         b = $random(seed);
         execute(encode_op(3'(f), 1'b0), a, a);
         execute(encode_op(3'(f), 1'b0), a, a ^ 32'h8000_0000);
         execute(encode_op(3'(f), 1'b0), a, b);
         imm  = 12'($random(seed));
         simm = {{20{imm[11]}}, imm};
         a    = $random(seed);
         execute(encode_opimm(3'(f), imm), simm, 32'h0);
         execute(encode_opimm(3'(f), imm), simm ^ 32'h8000_0000, 32'h0);
         execute(encode_opimm(3'(f), imm), a, 32'h0);
      end

      for (int i = 0; i < 3; i++) begin
         a = $random(seed);
         execute(encode_lui(a[19:0]), 32'h0, 32'h0);
      end

      for (int i = 0; i < 6; i++) begin
         a = $random(seed);
         b = $random(seed);
         execute(encode_branch(BRANCH_F3[i*3 +: 3], b[12:0]), a, a);
         execute(encode_branch(BRANCH_F3[i*3 +: 3], b[12:0]), a, a ^ 32'h8000_0000);
         execute(encode_branch(BRANCH_F3[i*3 +: 3], b[12:0]), a, b);
      end

      a = $random(seed);
      execute(encode_store(a[11:0]), a, 32'h1234_5678);

      repeat (2) @(negedge clk);
      if (n_results == n_issued) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("Result count wrong: %0d issued, %0d results seen", n_issued, n_results);
         abort_run();
      end
   end

endmodule

`default_nettype wire

/* all.f */
rtl/serial_pkg.sv
rtl/instr_decode.sv
rtl/imm_decode.sv
rtl/serial_regs.sv
rtl/serial_alu.sv
rtl/serial_exec_top.sv
dv/tb_serial_exec.sv
